/* bench/flash_model.sv */
`timescale 1ns/1ps

module flash_model import flash_row_pkg::*; (
    input  logic         spi_sel_n,
    input  logic         spi_clk,
    input  logic [3:0]   spi_io_out,
    input  logic [3:0]   spi_io_oe,
    output logic [3:0]   spi_io_in,
    output logic [4:0]   row_index,  // vector row asked for
    input  logic [127:0] row_data,   // that row, from the testbench array
    output logic [7:0]   cmd_rx,
    output flash_addr_t  addr_rx,
    output logic         oe_ok,      // io0 driven in command and address only
    output int           txn_count   // bumps at the end of the dummy phase
);

    int          edge_cnt;  // spi_clk rising edges inside one select
    int          nib;
    logic [31:0] rx_shift;  // opcode then address

    initial begin
        spi_io_in = '0;
        row_index = '0;
        cmd_rx    = '0;
        addr_rx   = '0;
        oe_ok     = 1'b1;
        txn_count = 0;
        edge_cnt  = 0;
        rx_shift  = '0;
    end

    // deselect ends the transaction
    always @(posedge spi_sel_n) begin
        edge_cnt  = 0;
        spi_io_in = '0;
    end

    always @(posedge spi_clk) begin
        if (!spi_sel_n) begin
            edge_cnt = edge_cnt + 1;
            if (edge_cnt == 1) begin
                oe_ok = 1'b1;
            end
            if (edge_cnt <= cmd_bits + addr_bits) begin
                rx_shift = {rx_shift[30:0], spi_io_out[0]};  // msb first
                if (!spi_io_oe[0]) begin
                    oe_ok = 1'b0;
                end
            end else if (edge_cnt <= cmd_bits + addr_bits + dummy_cycles) begin
                if (spi_io_oe[0]) begin
                    oe_ok = 1'b0;  // bus must be released for the turnaround
                end
                if (edge_cnt == cmd_bits + addr_bits + dummy_cycles) begin
                    cmd_rx    = rx_shift[31:24];
                    addr_rx   = rx_shift[23:0];
                    row_index = 5'((addr_rx / bytes_per_row) % 32);
                    txn_count = txn_count + 1;
                end
            end else begin
                // nibble n in read cycle n, msb nibble first
                nib = edge_cnt - (cmd_bits + addr_bits + dummy_cycles + 1);
                if (nib < read_nibbles) begin
                    spi_io_in = row_data[127 - 4 * nib -: 4];
                end else begin
                    spi_io_in = '0;
                end
            end
        end
    end

endmodule

/* bench/player_tb.sv */
`timescale 1ns/1ps

module player_tb import vga_timing_pkg::*, flash_row_pkg::*; ();

    localparam int clk_period_ns = 4;
    localparam int fetch_checks  = 70;
    // start-up and three frames plus slack
    localparam int watchdog_ns   = 3 * h_total * v_total * clk_period_ns + 10000;

    logic         px_clk;
    logic         rst_n;
    color3_t      color_on;
    color3_t      color_off;
    logic [3:0]   spi_io_in;
    rgb6_t        rgb;
    logic         hsync;
    logic         vsync;
    logic         spi_sel_n;
    logic         spi_clk;
    logic         audio_p;
    logic         audio_n;
    logic [3:0]   spi_io_out;
    logic [3:0]   spi_io_oe;

    logic [127:0] vec_rows [0:31];  // flash contents and expected rows
    logic [4:0]   row_index;
    logic [127:0] row_data;
    logic [7:0]   cmd_rx;
    flash_addr_t  addr_rx;
    logic         oe_ok;
    int           txn_count;

    int           ref_h = 0;  // beam position of the sampled outputs
    int           ref_v = 0;
    int           ref_frame = 0;
    logic         h_locked = 1'b0;
    logic         v_locked = 1'b0;
    logic         prev_vsync = 1'b1;
    logic         frames_done = 1'b0;
    logic         fetches_done = 1'b0;
    int           duty_cnt = 0;
    int           error_count = 0;

    px_clock_gen px_clock_gen_i (.px_clk(px_clk), .rst_n(rst_n));

    flash_model flash_model_i (
        .spi_sel_n(spi_sel_n), .spi_clk(spi_clk), .spi_io_out(spi_io_out),
        .spi_io_oe(spi_io_oe), .spi_io_in(spi_io_in), .row_index(row_index),
        .row_data(row_data), .cmd_rx(cmd_rx), .addr_rx(addr_rx), .oe_ok(oe_ok),
        .txn_count(txn_count)
    );

    assign row_data = vec_rows[row_index];

    vga_player_top vga_player_top_i (
        .px_clk(px_clk), .rst_n(rst_n), .color_on(color_on), .color_off(color_off),
        .spi_io_in(spi_io_in), .rgb(rgb), .hsync(hsync), .vsync(vsync),
        .spi_sel_n(spi_sel_n), .spi_clk(spi_clk), .audio_p(audio_p), .audio_n(audio_n),
        .spi_io_out(spi_io_out), .spi_io_oe(spi_io_oe)
    );

    task automatic report_mismatch(input string msg);
        error_count++;
        $display("CHECK FAILED at %0t ns: %s (frame %0d line %0d pixel %0d)",
                 $time, msg, ref_frame, ref_v, ref_h);
        $display("TEST FAILED");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic check_addr(input flash_addr_t got, input flash_addr_t exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: got %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_rgb(input rgb6_t got, input rgb6_t exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: got %b, expected %b", what, got, exp));
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: got %b, expected %b", what, got, exp));
        end
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: got %0d, expected %0d", what, got, exp));
        end
    endtask

    // one select bit becomes a two-bit channel
    function automatic rgb6_t widen_color(input color3_t c);
        rgb6_t w;
        for (int i = 0; i < 3; i++) begin
            w[2 * i +: 2] = {2{c[i]}};
        end
        return w;
    endfunction

    function automatic flash_addr_t expected_addr(input int n);
        return flash_addr_t'((n / band_count) * bytes_per_frame
                             + (n % band_count) * bytes_per_row);
    endfunction

    function automatic logic [127:0] row_for_band(input int frame, input int band);
        flash_addr_t addr;
        addr = flash_addr_t'(frame * bytes_per_frame + band * bytes_per_row);
        return vec_rows[(addr / bytes_per_row) % 32];
    endfunction

    // fresh colour pair that always tells lit and dark pixels apart
    task automatic draw_colors();
        color_on  = color3_t'($urandom);
        color_off = color_on ^ color3_t'(1 + $urandom % 7);
    endtask

    // advance the reference beam and lock it on the first sync edges
    task automatic follow_beam();
        if (h_locked) begin
            ref_h++;
            if (ref_h == h_total) begin
                ref_h = 0;
                if (v_locked) begin
                    ref_v++;
                    if (ref_v == v_total) begin
                        ref_v = 0;
                        ref_frame++;
                    end
                end
            end
        end else if (!hsync) begin
            h_locked = 1'b1;
            ref_h    = h_sync_start;
        end
        if (h_locked && !v_locked && !vsync) begin
            v_locked  = 1'b1;
            ref_v     = v_sync_start;  // first vsync falls in frame 0
            ref_frame = 0;
            check_level(ref_h == 0, 1'b1, "vsync edge at the start of a line");
        end
    endtask

    task automatic compare_pixel();
        int           band;
        int           frame;
        logic [127:0] row;
        logic         lit;
        band  = ref_v / lines_per_band;
        frame = ref_frame;
        // new band row shows up one pixel into its first line
        if ((ref_v % lines_per_band == 0) && (ref_h == 0)) begin
            if (band == 0) begin
                band  = band_count - 1;
                frame = frame - 1;
            end else begin
                band = band - 1;
            end
        end
        row = row_for_band(frame, band);
        lit = (ref_h < h_active) && (ref_v < v_active) && row[79 - ref_h / px_per_block];
        check_rgb(rgb, lit ? widen_color(color_on) : widen_color(color_off), "rgb");
    endtask

    // 256 cycles well inside each half band where the threshold is steady
    task automatic measure_duty();
        logic [127:0] row;
        if ((ref_v % lines_per_band == 0) || (ref_v % lines_per_band == lines_per_band / 2)) begin
            if (ref_h == 16) begin
                duty_cnt = 0;
            end
            if ((ref_h >= 16) && (ref_h < 272)) begin
                duty_cnt += audio_p;
            end
            if (ref_h == 271) begin
                row = row_for_band(ref_frame, ref_v / lines_per_band);
                check_byte(8'(duty_cnt),
                           (ref_v % lines_per_band == 0) ? row[127:120] : row[119:112],
                           "audio duty over 256 cycles");
            end
        end
    endtask

    initial begin
        $readmemh("bench/player_vectors.hex", vec_rows);
        void'($urandom(59779));
        draw_colors();
    end

    // levels while reset is held
    initial begin
        @(negedge px_clk);
        check_level(hsync, 1'b1, "hsync in reset");
        check_level(vsync, 1'b1, "vsync in reset");
        check_level(spi_sel_n, 1'b1, "flash select in reset");
        check_level(spi_clk, 1'b0, "flash clock in reset");
        check_level(spi_io_oe == 4'h0, 1'b1, "io enables in reset");
        check_level(audio_p, 1'b0, "audio_p in reset");
        check_level(audio_n, 1'b1, "audio_n in reset");
    end

    // opcode, address and bus direction of every fetch
    initial begin
        wait (rst_n === 1'b1);
        for (int n = 0; n < fetch_checks; n++) begin
            wait (txn_count > n);
            check_byte(cmd_rx, read_cmd, "read opcode");
            check_addr(addr_rx, expected_addr(n), $sformatf("address of fetch %0d", n));
            check_level(oe_ok, 1'b1, "io0 enable outside command and address");
        end
        fetches_done = 1'b1;
    end

    // display side is sampled and driven on the falling edge
    initial begin
        wait (rst_n === 1'b1);
        while (!frames_done) begin
            @(negedge px_clk);
            check_level(audio_n, ~audio_p, "audio_n against audio_p");
            follow_beam();
            if (v_locked && (ref_frame == 3)) begin
                frames_done = 1'b1;
            end else begin
                if (h_locked) begin
                    check_level(hsync, !((ref_h >= h_sync_start) && (ref_h < h_sync_end)), "hsync");
                end
                if (v_locked) begin
                    check_level(vsync, !((ref_v >= v_sync_start) && (ref_v < v_sync_end)), "vsync");
                    compare_pixel();
                    measure_duty();
                end
                if (prev_vsync && !vsync) begin
                    draw_colors();  // new colours each frame
                end
                prev_vsync = vsync;
            end
        end
    end

    initial begin
        wait (frames_done && fetches_done);
        @(negedge px_clk);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("run timed out before all frames and fetches were checked");
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

/* bench/player_vectors.hex */
// one 128-bit flash row per line, row n sits at byte address n*16
// sample0 sample1 sample2 (4 hex digits each), then 80 pixel bits (20 hex digits)
804012345678F0F0F0F0F0F0F0F0F0F0
FF000000FFFF0123456789ABCDEF0123
00FF7FFF8000FFFFFFFFFFFFFFFFFFFF
10E0A5A55A5A00000000000000000000
3C3C0F0FF0F0AAAAAAAAAAAAAAAAAAAA
C3011111222255555555555555555555
7F803333444480000000000000000001
010255556666FEDCBA9876543210FEDC
2040777788880F0F0F0F0F0F0F0F0F0F
608099999AAAA3C3C3C3C3C3C3C3C3C3
A0C0BBBBCCCCC3C3C3C3C3C3C3C3C3C3
E0FEDDDDEEEE18181818181818181818
0100000100027E7E7E7E7E7E7E7E7E7E
9A5B0003000481818181818181818181
44BB00050006FFFF0000FFFF0000FFFF
D2E1000700080000FFFF0000FFFF0000
55660009000A13579BDF02468ACE1357
8899000B000C2468ACE013579BDF2468
0FF0000D000EF00FF00FF00FF00FF00F
F00F000F00100FF00FF00FF00FF00FF0
2B7C1000200011223344556677889900
6E913000400AAABBCCDDEEFF00112233
B3A45000600044556677889900AABBCC
1DC8700080DDDEEFF001122334455660
770190000A00077889900AABBCCDDEEF
01FEB000C00096699669966996699669
FE01D000E00069966996699669966996
3355F0000F0000FF00FF00FF00FF00FF
CCAA00F0000FFF00FF00FF00FF00FF00
9C63135724680000000000FFFFFFFFFF
4D2E9BDFACE0FFFFFFFFFF0000000000
80FFABCDEF01A5C3E7F19B2D4F6081A3

/* bench/px_clock_gen.sv */
`timescale 1ns/1ps

module px_clock_gen (
    output logic px_clk,
    output logic rst_n
);

    localparam real half_period = 2.0;  // 4 ns pixel clock

    initial begin
        px_clk = 1'b0;
        forever #(half_period) px_clk = ~px_clk;
    end

    // two cycles of reset, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge px_clk);
        @(negedge px_clk);
        rst_n = 1'b1;
    end

endmodule

/* build.f */
verilog/vga_timing_pkg.sv
verilog/flash_row_pkg.sv
verilog/vga_sync_gen.sv
verilog/quad_flash_reader.sv
verilog/row_scheduler.sv
verilog/pixel_painter.sv
verilog/audio_pwm.sv
verilog/vga_player_top.sv
bench/px_clock_gen.sv
bench/flash_model.sv
bench/player_tb.sv

/* verilog/audio_pwm.sv */
`timescale 1ns/1ps

module audio_pwm import vga_timing_pkg::*, flash_row_pkg::*; (
    input  logic      px_clk,
    input  logic      rst_n,
    input  hcount_t   hcount,
    input  vcount_t   vcount,
    input  row_word_t display_row,
    input  logic      band_load,  // new row just went on display
    output logic      audio_p,
    output logic      audio_n
);

    logic [7:0] pwm_cnt;    // free running, 256 cycle period
    logic [7:0] threshold;  // duty in counts
    logic       mid_band;   // line 4 of a band
    sample_t    sample0;

    assign sample0  = display_row.fields.sample0;
    assign mid_band = (hcount == '0) && ((vcount % lines_per_band) == (lines_per_band / 2));

    always_ff @(posedge px_clk or negedge rst_n) begin
        if (!rst_n) begin
            pwm_cnt   <= '0;
            threshold <= '0;
            audio_p   <= 1'b0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
            if (band_load) begin
                threshold <= sample0[15:8];  // upper byte for the first half band
            end else if (mid_band) begin
                threshold <= sample0[7:0];
            end
            audio_p <= (pwm_cnt < threshold);
        end
    end

    assign audio_n = ~audio_p;  // differential pair

endmodule

/* verilog/flash_row_pkg.sv */
package flash_row_pkg;

    // fast read quad output, data comes back on io[3:0]
    localparam logic [7:0] read_cmd = 8'h6B;

    // transaction phase lengths in px_clk cycles
    localparam int cmd_bits     = 8;
    localparam int addr_bits    = 24;
    localparam int dummy_cycles = 8;
    localparam int read_nibbles = 32;  // 16 bytes per row

    localparam int bytes_per_row   = 16;
    localparam int bytes_per_frame = 1040;  // 65 rows

    typedef logic [23:0]  flash_addr_t;  // byte address
    typedef logic [15:0]  frame_t;
    typedef logic [6:0]   band_t;
    typedef logic [15:0]  sample_t;
    typedef logic [79:0]  pixel_row_t;   // one bit per 8-pixel block, msb is leftmost

    // decoded view of one flash row, msb first as it leaves the flash
    typedef struct packed {
        sample_t    sample0;  // drives the pwm
        sample_t    sample1;
        sample_t    sample2;
        pixel_row_t pixels;
    } row_fields_t;

    // reader fills raw nibbles, display side reads fields
    typedef union packed {
        logic [127:0] raw;
        row_fields_t  fields;
    } row_word_t;

endpackage

/* verilog/pixel_painter.sv */
`timescale 1ns/1ps

module pixel_painter import vga_timing_pkg::*, flash_row_pkg::*; (
    input  logic      px_clk,
    input  logic      rst_n,
    input  hcount_t   hcount,
    input  logic      active,
    input  logic      hsync_raw,
    input  logic      vsync_raw,
    input  row_word_t display_row,
    input  color3_t   color_on,
    input  color3_t   color_off,
    output rgb6_t     rgb,
    output logic      hsync,
    output logic      vsync
);

    block_t block;  // 8-pixel block under the beam
    logic   lit;

    // each select bit fills a 2-bit channel
    function automatic rgb6_t expand(input color3_t c);
        return {c[2], c[2], c[1], c[1], c[0], c[0]};
    endfunction

    assign block = block_t'(hcount / px_per_block);
    // leftmost block is the pixel msb, blanking never looks at the bit
    assign lit   = active && display_row.fields.pixels[($bits(pixel_row_t) - 1) - block];

    // one stage, keeps colour and syncs aligned
    always_ff @(posedge px_clk or negedge rst_n) begin
        if (!rst_n) begin
            rgb   <= '0;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            rgb   <= lit ? expand(color_on) : expand(color_off);
            hsync <= hsync_raw;
            vsync <= vsync_raw;
        end
    end

endmodule

/* verilog/quad_flash_reader.sv */
`timescale 1ns/1ps

module quad_flash_reader import flash_row_pkg::*; (
    input  logic        px_clk,
    input  logic        rst_n,
    input  logic        fetch_start,  // one-cycle request, only while idle
    input  flash_addr_t fetch_addr,   // stable until fetch_done
    output row_word_t   fetch_row,
    output logic        fetch_done,
    output logic        spi_sel_n,
    output logic        spi_clk,
    output logic [3:0]  spi_io_out,
    output logic [3:0]  spi_io_oe,
    input  logic [3:0]  spi_io_in
);

    typedef enum logic [2:0] {
        st_idle,
        st_select,  // chip select only
        st_oe,      // io0 driven, clock still off
        st_cmd,
        st_addr,
        st_dummy,
        st_read,
        st_done     // row valid, select drops next
    } phase_t;

    phase_t                        phase;
    logic [5:0]                    bit_cnt;   // position inside the current phase
    logic [cmd_bits+addr_bits-1:0] tx_shift;  // opcode then address, msb goes out first
    logic [3:0]                    io_in_q;   // flash nibble, one cycle late
    logic                          sel_on;
    logic                          clk_en;
    logic                          oe_q;

    assign spi_sel_n  = ~sel_on;
    // flash samples io0 on the rising spi_clk, mid px_clk cycle
    assign spi_clk    = ~px_clk & clk_en;
    assign spi_io_out = {3'b000, tx_shift[cmd_bits+addr_bits-1]};  // serial out on io0 only
    assign spi_io_oe  = {3'b000, oe_q};

    // receive path, nibble k lands one cycle after the flash drives it
    always_ff @(posedge px_clk) begin
        io_in_q <= spi_io_in;
        if ((phase == st_read) && (bit_cnt != '0)) begin
            fetch_row.raw <= {fetch_row.raw[$bits(row_word_t)-5:0], io_in_q};  // msb nibble first
        end
    end

    always_ff @(posedge px_clk or negedge rst_n) begin
        if (!rst_n) begin
            phase      <= st_idle;
            bit_cnt    <= '0;
            tx_shift   <= '0;
            sel_on     <= 1'b0;
            clk_en     <= 1'b0;
            oe_q       <= 1'b0;
            fetch_done <= 1'b0;
        end else begin
            fetch_done <= 1'b0;  // pulse
            case (phase)
                st_idle: begin
                    if (fetch_start) begin
                        phase  <= st_select;
                        sel_on <= 1'b1;
                    end
                end
                st_select: begin
                    phase    <= st_oe;
                    oe_q     <= 1'b1;
                    tx_shift <= {read_cmd, fetch_addr};
                end
                st_oe: begin
                    phase   <= st_cmd;
                    clk_en  <= 1'b1;  // clock and first opcode bit together
                    bit_cnt <= '0;
                end
                st_cmd: begin
                    tx_shift <= {tx_shift[cmd_bits+addr_bits-2:0], 1'b0};
                    if (bit_cnt == 6'(cmd_bits - 1)) begin
                        phase   <= st_addr;
                        bit_cnt <= '0;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                st_addr: begin
                    tx_shift <= {tx_shift[cmd_bits+addr_bits-2:0], 1'b0};
                    if (bit_cnt == 6'(addr_bits - 1)) begin
                        phase   <= st_dummy;
                        bit_cnt <= '0;
                        oe_q    <= 1'b0;  // release io0 before the turnaround
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                st_dummy: begin
                    if (bit_cnt == 6'(dummy_cycles - 1)) begin
                        phase   <= st_read;
                        bit_cnt <= '0;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                st_read: begin
                    // read cycle 0 only fills io_in_q
                    if (bit_cnt == 6'(read_nibbles)) begin
                        phase      <= st_done;
                        fetch_done <= 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                st_done: begin
                    phase  <= st_idle;
                    sel_on <= 1'b0;
                    clk_en <= 1'b0;
                end
                default: phase <= st_idle;
            endcase
        end
    end

endmodule

/* verilog/row_scheduler.sv */
`timescale 1ns/1ps

module row_scheduler import vga_timing_pkg::*, flash_row_pkg::*; (
    input  logic        px_clk,
    input  logic        rst_n,
    input  hcount_t     hcount,
    input  vcount_t     vcount,
    input  row_word_t   fetch_row,
    input  logic        fetch_done,
    output logic        fetch_start,
    output flash_addr_t fetch_addr,
    output row_word_t   display_row,
    output logic        band_load,
    output logic        run
);

    row_word_t cache_row;   // next band, waits for the band boundary
    band_t     next_band;   // band of the next fetch
    frame_t    next_frame;  // wraps freely
    logic      boot;        // first fetch not issued yet
    logic      skip_swap;   // band 0 is already shown on the very first line 0
    logic      band_tick;
    logic      first_done;
    logic      swap;
    logic      issue;

    assign band_tick  = run && (hcount == '0) && ((vcount % lines_per_band) == 0);
    assign first_done = fetch_done && !run;  // row for band 0 of frame 0
    assign swap       = band_tick && !skip_swap;
    assign issue      = boot || first_done || swap;

    always_ff @(posedge px_clk or negedge rst_n) begin
        if (!rst_n) begin
            boot        <= 1'b1;
            skip_swap   <= 1'b1;
            run         <= 1'b0;
            band_load   <= 1'b0;
            fetch_start <= 1'b0;
            fetch_addr  <= '0;
            next_band   <= '0;
            next_frame  <= '0;
        end else begin
            boot        <= 1'b0;
            fetch_start <= issue;           // reader is idle by then
            band_load   <= first_done || swap;
            if (first_done) begin
                run <= 1'b1;                // stays high
            end
            if (band_tick) begin
                skip_swap <= 1'b0;
            end
            if (issue) begin
                // frame * 1040 + band * 16, top bits dropped
                fetch_addr <= flash_addr_t'(next_frame * bytes_per_frame
                                            + next_band * bytes_per_row);
                if (next_band == band_t'(band_count - 1)) begin
                    next_band  <= '0;
                    next_frame <= next_frame + 1'b1;
                end else begin
                    next_band <= next_band + 1'b1;
                end
            end
        end
    end

    // row double buffer
    always_ff @(posedge px_clk) begin
        if (first_done) begin
            display_row <= fetch_row;
        end else if (swap) begin
            display_row <= cache_row;
        end
        if (fetch_done && run) begin
            cache_row <= fetch_row;
        end
    end

endmodule

/* verilog/vga_player_top.sv */
`timescale 1ns/1ps

module vga_player_top import vga_timing_pkg::*, flash_row_pkg::*; (
    input  logic       px_clk,
    input  logic       rst_n,
    input  color3_t    color_on,
    input  color3_t    color_off,
    input  logic [3:0] spi_io_in,
    output rgb6_t      rgb,
    output logic       hsync,
    output logic       vsync,
    output logic       spi_sel_n,
    output logic       spi_clk,
    output logic       audio_p,
    output logic       audio_n,
    output logic [3:0] spi_io_out,
    output logic [3:0] spi_io_oe
);

    hcount_t     hcount;
    vcount_t     vcount;
    logic        hsync_raw;   // combinational decode, painter registers it
    logic        vsync_raw;
    logic        active;
    logic        run;
    logic        fetch_start;
    logic        fetch_done;
    flash_addr_t fetch_addr;
    row_word_t   fetch_row;
    row_word_t   display_row;
    logic        band_load;

    vga_sync_gen vga_sync_gen_i (
        .px_clk (px_clk),
        .rst_n  (rst_n),
        .run    (run),
        .hcount (hcount),
        .vcount (vcount),
        .hsync  (hsync_raw),
        .vsync  (vsync_raw),
        .active (active)
    );

    quad_flash_reader quad_flash_reader_i (
        .px_clk      (px_clk),
        .rst_n       (rst_n),
        .fetch_start (fetch_start),
        .fetch_addr  (fetch_addr),
        .fetch_row   (fetch_row),
        .fetch_done  (fetch_done),
        .spi_sel_n   (spi_sel_n),
        .spi_clk     (spi_clk),
        .spi_io_out  (spi_io_out),
        .spi_io_oe   (spi_io_oe),
        .spi_io_in   (spi_io_in)
    );

    row_scheduler row_scheduler_i (
        .px_clk      (px_clk),
        .rst_n       (rst_n),
        .hcount      (hcount),
        .vcount      (vcount),
        .fetch_row   (fetch_row),
        .fetch_done  (fetch_done),
        .fetch_start (fetch_start),
        .fetch_addr  (fetch_addr),
        .display_row (display_row),
        .band_load   (band_load),
        .run         (run)
    );

    pixel_painter pixel_painter_i (
        .px_clk      (px_clk),
        .rst_n       (rst_n),
        .hcount      (hcount),
        .active      (active),
        .hsync_raw   (hsync_raw),
        .vsync_raw   (vsync_raw),
        .display_row (display_row),
        .color_on    (color_on),
        .color_off   (color_off),
        .rgb         (rgb),
        .hsync       (hsync),
        .vsync       (vsync)
    );

    audio_pwm audio_pwm_i (
        .px_clk      (px_clk),
        .rst_n       (rst_n),
        .hcount      (hcount),
        .vcount      (vcount),
        .display_row (display_row),
        .band_load   (band_load),
        .audio_p     (audio_p),
        .audio_n     (audio_n)
    );

endmodule

/* verilog/vga_sync_gen.sv */
`timescale 1ns/1ps

module vga_sync_gen import vga_timing_pkg::*; (
    input  logic    px_clk,
    input  logic    rst_n,
    input  logic    run,      // high once the first row is on display
    output hcount_t hcount,
    output vcount_t vcount,
    output logic    hsync,
    output logic    vsync,
    output logic    active
);

    logic h_last;  // last pixel of a line
    logic v_last;  // last line of a frame
    logic h_pulse;
    logic v_pulse;

    assign h_last = (hcount == hcount_t'(h_total - 1));
    assign v_last = (vcount == vcount_t'(v_total - 1));

    // line and frame counters
    always_ff @(posedge px_clk or negedge rst_n) begin
        if (!rst_n) begin
            hcount <= '0;
            vcount <= '0;
        end else if (!run) begin
            hcount <= '0;  // parked at the top left corner
            vcount <= '0;
        end else if (h_last) begin
            hcount <= '0;
            if (v_last) begin
                vcount <= '0;
            end else begin
                vcount <= vcount + 1'b1;
            end
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    // sync windows, pulses are active low
    assign h_pulse = (hcount >= h_sync_start) && (hcount < h_sync_end);
    assign v_pulse = (vcount >= v_sync_start) && (vcount < v_sync_end);
    assign hsync   = ~h_pulse;
    assign vsync   = ~v_pulse;

    // visible area
    assign active = (hcount < h_active) && (vcount < v_active);

endmodule

/* verilog/vga_timing_pkg.sv */
package vga_timing_pkg;

    // 640x480 at 72 Hz, one pixel per px_clk
    localparam int h_active     = 640;
    localparam int h_sync_start = 664;  // after front porch
    localparam int h_sync_end   = 704;  // 40 pixel sync pulse
    localparam int h_total      = 832;

    localparam int v_active     = 480;
    localparam int v_sync_start = 489;
    localparam int v_sync_end   = 492;  // 3 line sync pulse
    localparam int v_total      = 520;

    // picture grid
    localparam int lines_per_band = 8;   // one flash row per band
    localparam int band_count     = 65;  // 520 lines / 8
    localparam int px_per_block   = 8;

    typedef logic [9:0] hcount_t;
    typedef logic [9:0] vcount_t;
    typedef logic [6:0] block_t;   // 8-pixel block index along a line
    typedef logic [2:0] color3_t;  // r, g, b select bits
    typedef logic [5:0] rgb6_t;    // rrggbb to the dac

endpackage
